//--- hdl/axi_refill.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module axi_refill (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  refill_start,
    input  logic [31:0]           refill_addr,
    output cache_pkg::axi_ar_t    ar,
    input  logic                  arready,
    input  cache_pkg::axi_r_t     r,
    output cache_pkg::fill_t      fill,
    output cache_pkg::tag_load_t  tag_load,
    output logic                  busy,
    output logic                  rd_error
);

    import cache_pkg::*;

    localparam int IDX_BITS  = `CACHE_PAGE_BITS - 2;
    localparam int BEAT_BITS = $clog2(`AXI_BURST_BEATS);
    localparam logic [1:0] RESP_OKAY = 2'b00;

    ar_state_e                   ar_state;
    ar_state_e                   ar_next;
    r_state_e                    r_state;
    r_state_e                    r_next;
    logic [31:0]                 ar_addr;
    logic                        ar_valid;
    logic [`CACHE_TAG_BITS-1:0]  page_tag;
    logic [IDX_BITS-1:0]         fill_idx;
    logic                        beat;
    logic                        burst_done;
    logic                        page_done;
    logic                        load_q;

    assign beat       = (r_state == R_READ) && r.valid;
    assign burst_done = beat && r.last;
    // Address already stepped past the burst in flight
    assign page_done  = (ar_addr[`CACHE_PAGE_BITS-1:0] == '0);

    always_comb begin
        ar_next = ar_state;
        case (ar_state)
            AR_IDLE: begin
                if (refill_start) begin
                    ar_next = AR_ADDR;
                end
            end
            AR_ADDR: begin
                if (ar_valid && arready) begin
                    ar_next = AR_WAIT;
                end
            end
            AR_WAIT: begin
                if (burst_done) begin
                    ar_next = page_done ? AR_IDLE : AR_ADDR;
                end
            end
            default: ar_next = AR_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            ar_state <= AR_IDLE;
            ar_valid <= 1'b0;
        end else begin
            ar_state <= ar_next;
            if (ar_state == AR_ADDR && !ar_valid) begin
                ar_valid <= 1'b1;
            end else if (ar_valid && arready) begin
                ar_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (ar_state == AR_IDLE && refill_start) begin
            ar_addr  <= refill_addr;
            page_tag <= refill_addr[31:`CACHE_PAGE_BITS];
        end else if (ar_valid && arready) begin
            ar_addr <= ar_addr + 32'(`AXI_BURST_BYTES);
        end
    end

    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE: begin
                if (ar_state == AR_ADDR) begin
                    r_next = R_READ;
                end
            end
            R_READ: begin
                if (burst_done) begin
                    r_next = R_IDLE;
                end
            end
            default: r_next = R_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            r_state <= R_IDLE;
        end else begin
            r_state <= r_next;
        end
    end

    // Word index across the whole page
    always_ff @(posedge CLK) begin
        if (RST || ar_state == AR_IDLE) begin
            fill_idx <= '0;
        end else if (beat) begin
            fill_idx <= fill_idx + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            load_q   <= 1'b0;
            rd_error <= 1'b0;
        end else begin
            load_q   <= (ar_state == AR_WAIT) && burst_done && page_done;
            rd_error <= beat && (r.resp != RESP_OKAY);
        end
    end

    assign ar       = '{addr: ar_addr, valid: ar_valid};
    assign fill     = '{we: beat, index: fill_idx, data: r.data};
    assign tag_load = '{load: load_q, tag: page_tag};
    assign busy     = (ar_state != AR_IDLE) || load_q;

    a_ar_hold: assert property (@(posedge CLK) disable iff (RST)
        ar_valid && !arready |=> ar_valid && $stable(ar_addr));

    a_rlast_last_beat: assert property (@(posedge CLK) disable iff (RST)
        beat |-> (r.last == (fill_idx[BEAT_BITS-1:0] == BEAT_BITS'(`AXI_BURST_BEATS - 1))));

endmodule

`default_nettype wire

//--- hdl/cache_axi_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module cache_axi_top (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 STALL,
    input  logic [31:0]          HIT_CHECK,
    output logic                 HIT_CHECK_RESULT,
    input  logic                 RDEN,
    input  logic [31:0]          RIADDR,
    output logic [31:0]          ROADDR,
    output logic                 RVALID,
    output logic [31:0]          RDATA,
    input  cache_pkg::reg_bus_t  bus,
    output logic [31:0]          reg_rdata,
    output logic [31:0]          M_AXI_ARADDR,
    output logic [7:0]           M_AXI_ARLEN,
    output logic [2:0]           M_AXI_ARSIZE,
    output logic [1:0]           M_AXI_ARBURST,
    output logic                 M_AXI_ARVALID,
    input  logic                 M_AXI_ARREADY,
    input  logic [31:0]          M_AXI_RDATA,
    input  logic [1:0]           M_AXI_RRESP,
    input  logic                 M_AXI_RLAST,
    input  logic                 M_AXI_RVALID
);

    import cache_pkg::*;

    fill_t         fill;
    tag_load_t     tag_load;
    axi_ar_t       ar;
    axi_r_t        r;
    cache_event_t  events;
    logic          flush;
    logic          refill_busy;
    logic          refill_start;
    logic [31:0]   refill_addr;
    logic          rd_error;
    logic          hit;
    logic          miss;

    assign M_AXI_ARADDR  = ar.addr;
    assign M_AXI_ARVALID = ar.valid;
    assign M_AXI_ARLEN   = 8'(`AXI_BURST_BEATS - 1);
    assign M_AXI_ARSIZE  = `AXI_ARSIZE_VAL;
    assign M_AXI_ARBURST = `AXI_ARBURST_VAL;

    assign r = '{data: M_AXI_RDATA, resp: M_AXI_RRESP, last: M_AXI_RLAST,
                 valid: M_AXI_RVALID};

    assign events = '{hit: hit, miss: miss, refill_busy: refill_busy, rd_error: rd_error};

    page_cache cache_i (
        .CLK              (CLK),
        .RST              (RST),
        .STALL            (STALL),
        .HIT_CHECK        (HIT_CHECK),
        .HIT_CHECK_RESULT (HIT_CHECK_RESULT),
        .RDEN             (RDEN),
        .RIADDR           (RIADDR),
        .ROADDR           (ROADDR),
        .RVALID           (RVALID),
        .RDATA            (RDATA),
        .fill             (fill),
        .tag_load         (tag_load),
        .flush            (flush),
        .refill_busy      (refill_busy),
        .refill_start     (refill_start),
        .refill_addr      (refill_addr),
        .hit              (hit),
        .miss             (miss)
    );

    axi_refill refill_i (
        .CLK          (CLK),
        .RST          (RST),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .ar           (ar),
        .arready      (M_AXI_ARREADY),
        .r            (r),
        .fill         (fill),
        .tag_load     (tag_load),
        .busy         (refill_busy),
        .rd_error     (rd_error)
    );

    cache_ctrl_regs regs_i (
        .CLK       (CLK),
        .RST       (RST),
        .bus       (bus),
        .reg_rdata (reg_rdata),
        .events    (events),
        .flush     (flush)
    );

endmodule

`default_nettype wire

//--- hdl/cache_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_regs (
    input  logic                    CLK,
    input  logic                    RST,
    input  cache_pkg::reg_bus_t     bus,
    output logic [31:0]             reg_rdata,
    input  cache_pkg::cache_event_t events,
    output logic                    flush
);

    import cache_pkg::*;

    logic [31:0]  hits;
    logic [31:0]  misses;
    logic         rd_err;
    logic [31:0]  status;

    function automatic logic [31:0] sat_inc(input logic [31:0] v);
        return (v == '1) ? v : v + 32'd1;
    endfunction

    assign flush  = bus.wen && (bus.addr == REG_CTRL) && bus.wdata[0];
    assign status = {30'b0, rd_err, events.refill_busy};

    // Any write clears a counter
    always_ff @(posedge CLK) begin
        if (RST || (bus.wen && bus.addr == REG_HITS)) begin
            hits <= '0;
        end else if (events.hit) begin
            hits <= sat_inc(hits);
        end
    end

    always_ff @(posedge CLK) begin
        if (RST || (bus.wen && bus.addr == REG_MISSES)) begin
            misses <= '0;
        end else if (events.miss) begin
            misses <= sat_inc(misses);
        end
    end

    // A new error wins over the clearing write
    always_ff @(posedge CLK) begin
        if (RST) begin
            rd_err <= 1'b0;
        end else if (events.rd_error) begin
            rd_err <= 1'b1;
        end else if (bus.wen && bus.addr == REG_STATUS) begin
            rd_err <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.ren) begin
            case (bus.addr)
                REG_CTRL:   reg_rdata <= 32'b0;
                REG_STATUS: reg_rdata <= status;
                REG_HITS:   reg_rdata <= hits;
                REG_MISSES: reg_rdata <= misses;
                default:    reg_rdata <= 32'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
`default_nettype none
`include "cache_cfg.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        AR_IDLE = 2'b00,
        AR_ADDR = 2'b01,
        AR_WAIT = 2'b11
    } ar_state_e;

    typedef enum logic {
        R_IDLE = 1'b0,
        R_READ = 1'b1
    } r_state_e;

    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_HITS   = 2'd2,
        REG_MISSES = 2'd3
    } reg_addr_e;

    // One refill beat into the data array
    typedef struct packed {
        logic                         we;
        logic [`CACHE_PAGE_BITS-3:0]  index;
        logic [31:0]                  data;
    } fill_t;

    typedef struct packed {
        logic                         load;
        logic [`CACHE_TAG_BITS-1:0]   tag;
    } tag_load_t;

    typedef struct packed {
        logic [31:0]  addr;
        logic         valid;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0]  data;
        logic [1:0]   resp;
        logic         last;
        logic         valid;
    } axi_r_t;

    typedef struct packed {
        logic  hit;
        logic  miss;
        logic  refill_busy;
        logic  rd_error;
    } cache_event_t;

    typedef struct packed {
        logic         wen;
        logic         ren;
        reg_addr_e    addr;
        logic [31:0]  wdata;
    } reg_bus_t;

endpackage

`default_nettype wire

//--- hdl/page_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module page_cache (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  STALL,
    input  logic [31:0]           HIT_CHECK,
    output logic                  HIT_CHECK_RESULT,
    input  logic                  RDEN,
    input  logic [31:0]           RIADDR,
    output logic [31:0]           ROADDR,
    output logic                  RVALID,
    output logic [31:0]           RDATA,
    input  cache_pkg::fill_t      fill,
    input  cache_pkg::tag_load_t  tag_load,
    input  logic                  flush,
    input  logic                  refill_busy,
    output logic                  refill_start,
    output logic [31:0]           refill_addr,
    output logic                  hit,
    output logic                  miss
);

    localparam int TAG_LSB  = `CACHE_PAGE_BITS;
    localparam int IDX_BITS = `CACHE_PAGE_BITS - 2;

    logic [31:0]                 mem [0:`CACHE_WORDS-1];
    logic [`CACHE_TAG_BITS-1:0]  tag;
    logic                        rd_match;
    logic                        rd_hit;

    assign HIT_CHECK_RESULT = !RDEN || (HIT_CHECK[31:TAG_LSB] == tag);

    assign rd_match = (RIADDR[31:TAG_LSB] == tag);
    assign rd_hit   = RDEN && rd_match;

    // A hit is counted when the output stage takes it
    assign hit  = rd_hit && !STALL;
    // One miss per refill as busy also covers the tag load cycle
    assign miss = RDEN && !rd_match && !refill_busy;

    assign refill_start = miss;
    assign refill_addr  = {RIADDR[31:TAG_LSB], {`CACHE_PAGE_BITS{1'b0}}};

    always_ff @(posedge CLK) begin
        if (RST) begin
            tag <= '1;
        end else if (tag_load.load) begin
            tag <= tag_load.tag;
        end else if (refill_start || (flush && !refill_busy)) begin
            // Old page gets overwritten by the refill
            tag <= '1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill.we) begin
            mem[fill.index] <= fill.data;
        end
    end

    // Read stage frozen while stalled
    always_ff @(posedge CLK) begin
        if (RST) begin
            RVALID <= 1'b0;
        end else if (!STALL) begin
            RVALID <= rd_hit;
        end
    end

    always_ff @(posedge CLK) begin
        if (!STALL) begin
            ROADDR <= RIADDR;
            RDATA  <= rd_hit ? mem[RIADDR[IDX_BITS+1:2]] : 32'b0;
        end
    end

    // Tag only moves once the last word has been written
    a_fill_before_tag: assert property (@(posedge CLK) disable iff (RST)
        !(fill.we && tag_load.load));

endmodule

`default_nettype wire

//--- include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Page geometry
`define CACHE_WORDS      1024
`define CACHE_PAGE_BITS  12
`define CACHE_TAG_BITS   20

// One page is 32 AXI read bursts of 32 words
`define AXI_BURST_BEATS  32
`define AXI_BURST_BYTES  128

// 4-byte beats
`define AXI_ARSIZE_VAL   3'b010
// INCR
`define AXI_ARBURST_VAL  2'b01

`endif

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps -f tb.f \
    --top-module tb_cache_axi -o tb_cache_axi \
    && ./obj_dir/tb_cache_axi > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

//--- tb.f
+incdir+include
hdl/cache_pkg.sv
hdl/page_cache.sv
hdl/axi_refill.sv
hdl/cache_ctrl_regs.sv
hdl/cache_axi_top.sv
verification/axi_mem_model.sv
verification/tb_cache_axi.sv

//--- verification/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module axi_mem_model (
    input  logic         CLK,
    input  logic         RST,
    input  logic [31:0]  araddr,
    input  logic         arvalid,
    output logic         arready,
    output logic [31:0]  rdata,
    output logic [1:0]   rresp,
    output logic         rlast,
    output logic         rvalid,
    input  logic         err_en,
    input  logic [19:0]  err_page
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic         ar_rdy_q = 1'b0;
    logic [31:0]  data_q   = 32'b0;
    logic [1:0]   resp_q   = RESP_OKAY;
    logic         last_q   = 1'b0;
    logic         valid_q  = 1'b0;
    logic         active   = 1'b0;
    logic [31:0]  base     = 32'b0;
    int           beat     = 0;

    // Memory contents follow from the byte address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return (addr ^ 32'hA5A5_0000) + (addr >> 2);
    endfunction

    always @(posedge CLK) begin
        int nxt;
        if (RST) begin
            ar_rdy_q <= 1'b0;
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            active   <= 1'b0;
        end else if (!active) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            if (arvalid && ar_rdy_q) begin
                active   <= 1'b1;
                base     <= araddr;
                beat     <= 0;
                ar_rdy_q <= 1'b0;
            end else begin
                ar_rdy_q <= ($urandom % 3) != 0;
            end
        end else if (valid_q && last_q) begin
            // Burst ends once the final beat is taken
            active  <= 1'b0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            // Valid high on this edge means the beat was taken
            nxt = valid_q ? beat + 1 : beat;
            beat <= nxt;
            if (($urandom % 4) != 0) begin
                valid_q <= 1'b1;
                data_q  <= word_at(base + 32'(nxt * 4));
                resp_q  <= (err_en && base[31:`CACHE_PAGE_BITS] == err_page) ?
                           RESP_SLVERR : RESP_OKAY;
                last_q  <= (nxt == `AXI_BURST_BEATS - 1);
            end else begin
                valid_q <= 1'b0;
            end
        end
    end

    assign arready = ar_rdy_q;
    assign rdata   = data_q;
    assign rresp   = resp_q;
    assign rlast   = last_q;
    assign rvalid  = valid_q;

endmodule

`default_nettype wire

//--- verification/tb_cache_axi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_axi;

    import cache_pkg::*;

    localparam int          READ_TRIES = 4000;
    localparam logic [31:0] SEED       = 32'h3cb9_6b3f;

    logic         CLK = 1'b0;
    logic         RST;
    logic         stall;
    logic [31:0]  hit_check;
    logic         hit_check_result;
    logic         rden;
    logic [31:0]  riaddr;
    logic [31:0]  roaddr;
    logic         rvalid;
    logic [31:0]  rdata;
    reg_bus_t     bus;
    logic [31:0]  reg_rdata;
    logic [31:0]  m_araddr;
    logic [7:0]   m_arlen;
    logic [2:0]   m_arsize;
    logic [1:0]   m_arburst;
    logic         m_arvalid;
    logic         m_arready;
    logic [31:0]  m_rdata;
    logic [1:0]   m_rresp;
    logic         m_rlast;
    logic         m_rvalid;
    logic         err_en;
    logic [19:0]  err_page;
    logic [31:0]  read_addr;

    int errors = 0;
    int checks = 0;
    int tests  = 0;

    always #50 CLK = ~CLK;

    cache_axi_top dut_i (
        .CLK              (CLK),
        .RST              (RST),
        .STALL            (stall),
        .HIT_CHECK        (hit_check),
        .HIT_CHECK_RESULT (hit_check_result),
        .RDEN             (rden),
        .RIADDR           (riaddr),
        .ROADDR           (roaddr),
        .RVALID           (rvalid),
        .RDATA            (rdata),
        .bus              (bus),
        .reg_rdata        (reg_rdata),
        .M_AXI_ARADDR     (m_araddr),
        .M_AXI_ARLEN      (m_arlen),
        .M_AXI_ARSIZE     (m_arsize),
        .M_AXI_ARBURST    (m_arburst),
        .M_AXI_ARVALID    (m_arvalid),
        .M_AXI_ARREADY    (m_arready),
        .M_AXI_RDATA      (m_rdata),
        .M_AXI_RRESP      (m_rresp),
        .M_AXI_RLAST      (m_rlast),
        .M_AXI_RVALID     (m_rvalid)
    );

    axi_mem_model mem_i (
        .CLK      (CLK),
        .RST      (RST),
        .araddr   (m_araddr),
        .arvalid  (m_arvalid),
        .arready  (m_arready),
        .rdata    (m_rdata),
        .rresp    (m_rresp),
        .rlast    (m_rlast),
        .rvalid   (m_rvalid),
        .err_en   (err_en),
        .err_page (err_page)
    );

    // Expected memory word for a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr ^ 32'hA5A5_0000) + (addr >> 2);
    endfunction

    function automatic logic [31:0] page_addr(input logic [19:0] page);
        logic [31:0] r;
        r = $urandom;
        return {page, r[9:0], 2'b00};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("Test %0d, %s: ok", tests, name);
        end else begin
            $display("Test %0d, %s: %0d errors", tests, name, errors - mark);
        end
    endtask

    // One strobe per try with RVALID sampled one cycle later
    task automatic read_word(input logic [31:0] addr, output int tries);
        bit got;
        got   = 1'b0;
        tries = 0;
        while (!got && tries < READ_TRIES) begin
            @(posedge CLK);
            read_addr = addr;
            rden   <= 1'b1;
            riaddr <= addr;
            @(posedge CLK);
            rden <= 1'b0;
            @(negedge CLK);
            tries++;
            got = rvalid;
        end
        if (!got) begin
            errors++;
            $display("Read of address %h returned no RVALID after %0d tries", addr, tries);
        end else begin
            check("ROADDR", roaddr, addr);
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        @(posedge CLK);
        bus <= '{wen: 1'b1, ren: 1'b0, addr: addr, wdata: data};
        @(posedge CLK);
        bus <= '{wen: 1'b0, ren: 1'b0, addr: REG_CTRL, wdata: 32'b0};
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        @(posedge CLK);
        bus <= '{wen: 1'b0, ren: 1'b1, addr: addr, wdata: 32'b0};
        @(posedge CLK);
        bus <= '{wen: 1'b0, ren: 1'b0, addr: REG_CTRL, wdata: 32'b0};
        @(negedge CLK);
        data = reg_rdata;
    endtask

    // Every returned word against the memory contents
    always @(negedge CLK) begin
        if (!RST && rvalid) begin
            check("RDATA", rdata, mem_word(read_addr));
        end
    end

    initial begin
        logic [19:0] page_a;
        logic [19:0] page_b;
        logic [31:0] addr;
        logic [31:0] rd;
        logic [31:0] rnd;
        int          tries;
        int          mark;
        int          exp_hits;
        int          exp_misses;

        void'($urandom(SEED));
        RST       = 1'b1;
        stall     = 1'b0;
        hit_check = 32'b0;
        rden      = 1'b0;
        riaddr    = 32'b0;
        bus       = '0;
        err_en    = 1'b0;
        read_addr = 32'b0;
        rnd       = $urandom;
        // Bit 19 clear keeps these pages away from the reset tag
        page_a    = {1'b0, rnd[18:0]};
        page_b    = page_a ^ 20'h2_0001;
        err_page  = page_a ^ 20'h1_0002;
        repeat (2) @(posedge CLK);
        RST <= 1'b0;

        mark = errors;
        read_word(page_addr(page_a), tries);
        check("retry count above one for the first read", 32'(tries > 1), 32'd1);
        check("M_AXI_ARLEN", 32'(m_arlen), 32'd31);
        check("M_AXI_ARSIZE", 32'(m_arsize), 32'd2);
        check("M_AXI_ARBURST", 32'(m_arburst), 32'd1);
        repeat (16) begin
            read_word(page_addr(page_a), tries);
            check("tries for a same-page read", 32'(tries), 32'd1);
        end
        report("miss then refill", mark);

        mark = errors;
        addr = page_addr(page_a);
        @(posedge CLK);
        hit_check <= {page_b, 12'h0};
        @(negedge CLK);
        check("HIT_CHECK_RESULT", 32'(hit_check_result), 32'd1);
        @(posedge CLK);
        read_addr = addr;
        rden      <= 1'b1;
        riaddr    <= addr;
        hit_check <= addr;
        @(negedge CLK);
        check("HIT_CHECK_RESULT", 32'(hit_check_result), 32'd1);
        @(posedge CLK);
        hit_check <= {page_b, 12'h0};
        @(negedge CLK);
        check("HIT_CHECK_RESULT", 32'(hit_check_result), 32'd0);
        @(posedge CLK);
        stall  <= 1'b1;
        rden   <= 1'b0;
        riaddr <= addr ^ 32'h4;
        repeat (4) begin
            @(negedge CLK);
            check("ROADDR", roaddr, addr);
            check("RVALID", 32'(rvalid), 32'd1);
            check("RDATA", rdata, mem_word(addr));
        end
        @(posedge CLK);
        stall <= 1'b0;
        report("hit check and stall", mark);

        mark = errors;
        read_word(page_addr(page_b), tries);
        check("retry count above one for a new page", 32'(tries > 1), 32'd1);
        repeat (12) begin
            read_word(page_addr(page_b), tries);
            check("tries for a new-page read", 32'(tries), 32'd1);
        end
        read_word(page_addr(page_a), tries);
        check("retry count above one for the old page", 32'(tries > 1), 32'd1);
        report("page switch", mark);

        mark = errors;
        reg_write(REG_CTRL, 32'h1);
        read_word(page_addr(page_a), tries);
        check("retry count above one after flush", 32'(tries > 1), 32'd1);
        read_word(page_addr(page_a), tries);
        check("tries after the flush refill", 32'(tries), 32'd1);
        report("flush", mark);

        mark = errors;
        reg_write(REG_HITS, 32'h0);
        reg_write(REG_MISSES, 32'h0);
        exp_hits   = 0;
        exp_misses = 0;
        for (int i = 0; i < 8; i++) begin
            read_word(page_addr((i >= 3 && i <= 5) ? page_b : page_a), tries);
            exp_hits++;
            if (tries > 1) begin
                exp_misses++;
            end
        end
        check("misses in the read sequence", 32'(exp_misses), 32'd2);
        reg_read(REG_HITS, rd);
        check("REG_HITS", rd, 32'(exp_hits));
        reg_read(REG_MISSES, rd);
        check("REG_MISSES", rd, 32'(exp_misses));
        report("counters", mark);

        mark = errors;
        addr = page_addr(err_page);
        @(posedge CLK);
        err_en <= 1'b1;
        rden   <= 1'b1;
        riaddr <= addr;
        @(posedge CLK);
        rden <= 1'b0;
        reg_read(REG_STATUS, rd);
        check("REG_STATUS busy bit", 32'(rd[0]), 32'd1);
        read_word(addr, tries);
        reg_read(REG_STATUS, rd);
        check("REG_STATUS", rd, 32'h2);
        reg_read(REG_STATUS, rd);
        check("REG_STATUS", rd, 32'h2);
        reg_write(REG_STATUS, 32'h0);
        reg_read(REG_STATUS, rd);
        check("REG_STATUS", rd, 32'h0);
        @(posedge CLK);
        err_en <= 1'b0;
        report("read error", mark);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
